//--- rtl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int INSTR_W = 32;
    localparam int OP_W = 4;
    localparam int FUNC_W = 3;
    localparam int LREG_W = 5;
    localparam int NUM_LREGS = 32;

    // instruction class in bits 31..28
    typedef enum logic [OP_W-1:0] {
        Alu    = 4'd0,
        AluImm = 4'd1,
        Mem    = 4'd2,
        Branch = 4'd3,
        Jump   = 4'd4,
        Lui    = 4'd5
    } opcode_e;

    typedef enum logic [FUNC_W-1:0] {
        Add  = 3'd0,
        Sub  = 3'd1,
        And  = 3'd2,
        Or   = 3'd3,
        Xor  = 3'd4,
        Sll  = 3'd5,
        Mull = 3'd6
    } alu_func_e;

    typedef enum logic [FUNC_W-1:0] {
        Beq  = 3'd0,
        Bne  = 3'd1,
        Blt  = 3'd2,
        Beqz = 3'd3
    } branch_func_e;

    typedef enum logic [FUNC_W-1:0] {
        Load  = 3'd0,
        Store = 3'd1
    } mem_func_e;

    typedef enum logic [FUNC_W-1:0] {
        Jal  = 3'd0,
        Jalr = 3'd1
    } jump_func_e;

    // three register formats
    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [FUNC_W-1:0] func;
        logic [LREG_W-1:0] dst;
        logic [LREG_W-1:0] src1;
        logic [LREG_W-1:0] src2;
        logic [9:0]        unused;
    } r_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [FUNC_W-1:0] func;
        logic [LREG_W-1:0] dst;
        logic [LREG_W-1:0] src1;
        logic [14:0]       imm15;
    } i_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [FUNC_W-1:0] func;
        logic [LREG_W-1:0] dst;
        logic [19:0]       imm20;
    } j_fmt_t;

    // immediates overlap the source fields of the r view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

//--- rtl/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if #(
    parameter int SUPER = 2
);
    logic [SUPER-1:0]                           lane_valid;
    logic [SUPER-1:0][rename_pkg::OP_W-1:0]     op;
    logic [SUPER-1:0][rename_pkg::FUNC_W-1:0]   func;
    logic [SUPER-1:0][rename_pkg::LREG_W-1:0]   src1;
    logic [SUPER-1:0][rename_pkg::LREG_W-1:0]   src2;
    logic [SUPER-1:0]                           reads_src1;
    logic [SUPER-1:0]                           reads_src2;
    logic [SUPER-1:0][rename_pkg::LREG_W-1:0]   dst;
    logic [SUPER-1:0]                           has_dst;

    modport decoder (
        output lane_valid, op, func, src1, src2, reads_src1, reads_src2, dst, has_dst
    );

    modport rename (
        input lane_valid, op, func, src1, src2, reads_src1, reads_src2, dst, has_dst
    );
endinterface

`default_nettype wire

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
    parameter int SUPER = 2
) (
    input  rename_pkg::instr_u [SUPER-1:0]                in_instr,
    input  logic                                          in_valid,
    decode_if.decoder                                     dec,
    output logic [SUPER-1:0][rename_pkg::INSTR_W-1:0]     imm_out
);

    always_comb begin
        rename_pkg::instr_u                w;
        logic                              legal;
        logic                              rd1;
        logic                              rd2;
        logic                              wr;
        logic                              is_jump;
        logic                              ok;
        logic                              jump_seen;
        logic [rename_pkg::LREG_W-1:0]     s1;
        logic [rename_pkg::LREG_W-1:0]     s2;
        logic [rename_pkg::LREG_W-1:0]     d;
        logic [rename_pkg::INSTR_W-1:0]    imm;

        jump_seen = 1'b0;
        for (int l = 0; l < SUPER; l++) begin
            w = in_instr[l];
            legal = 1'b0;
            rd1 = 1'b0;
            rd2 = 1'b0;
            wr = 1'b0;
            is_jump = 1'b0;
            s1 = '0;
            s2 = '0;
            d = '0;
            imm = '0;
            case (rename_pkg::opcode_e'(w.r.op))
                rename_pkg::Alu: begin
                    legal = rename_pkg::alu_func_e'(w.r.func) <= rename_pkg::Mull;
                    {rd1, rd2, wr} = 3'b111;
                    s1 = w.r.src1;
                    s2 = w.r.src2;
                    d = w.r.dst;
                end
                rename_pkg::AluImm: begin
                    legal = rename_pkg::alu_func_e'(w.i.func) <= rename_pkg::Mull;
                    {rd1, wr} = 2'b11;
                    s1 = w.i.src1;
                    d = w.i.dst;
                    imm = {{17{w.i.imm15[14]}}, w.i.imm15};
                end
                rename_pkg::Mem: begin
                    case (rename_pkg::mem_func_e'(w.i.func))
                        rename_pkg::Load: begin
                            {legal, rd1, wr} = 3'b111;
                            s1 = w.i.src1;
                            d = w.i.dst;
                            imm = {{17{w.i.imm15[14]}}, w.i.imm15};
                        end
                        rename_pkg::Store: begin
                            {legal, rd1, rd2} = 3'b111;
                            s1 = w.r.src1;
                            s2 = w.r.src2;
                        end
                        default: legal = 1'b0;
                    endcase
                end
                rename_pkg::Branch: begin
                    legal = rename_pkg::branch_func_e'(w.r.func) <= rename_pkg::Beqz;
                    {rd1, rd2} = 2'b11;
                    s1 = w.r.src1;
                    s2 = w.r.src2;
                end
                rename_pkg::Jump: begin
                    case (rename_pkg::jump_func_e'(w.j.func))
                        rename_pkg::Jal: begin
                            {legal, wr, is_jump} = 3'b111;
                            d = w.j.dst;
                            imm = {{12{w.j.imm20[19]}}, w.j.imm20};
                        end
                        rename_pkg::Jalr: begin
                            {legal, rd1, wr, is_jump} = 4'b1111;
                            s1 = w.i.src1;
                            d = w.i.dst;
                            imm = {{17{w.i.imm15[14]}}, w.i.imm15};
                        end
                        default: legal = 1'b0;
                    endcase
                end
                rename_pkg::Lui: begin
                    legal = w.j.func == '0;
                    wr = 1'b1;
                    d = w.j.dst;
                    imm = {{12{w.j.imm20[19]}}, w.j.imm20};
                end
                default: legal = 1'b0;
            endcase

            // lanes behind a jump are dropped
            ok = in_valid && legal && !jump_seen;
            dec.lane_valid[l] = ok;
            dec.op[l] = ok ? w.r.op : '0;
            dec.func[l] = ok ? w.r.func : '0;
            dec.reads_src1[l] = ok && rd1;
            dec.reads_src2[l] = ok && rd2;
            dec.src1[l] = (ok && rd1) ? s1 : '0;
            dec.src2[l] = (ok && rd2) ? s2 : '0;
            // r0 is never a real destination
            dec.has_dst[l] = ok && wr && (d != '0);
            dec.dst[l] = (ok && wr) ? d : '0;
            imm_out[l] = ok ? imm : '0;
            jump_seen = jump_seen || (ok && is_jump);
        end
    end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int SUPER = 2,
    parameter int PHYS_SZ = 48,
    localparam int PREG_W = $clog2(PHYS_SZ),
    localparam int CNT_W = $clog2(PHYS_SZ + 1)
) (
    input  logic                          clk,
    input  logic                          rst,
    decode_if.rename                      dec,
    input  logic [SUPER-1:0]              commit_valid,
    input  logic [SUPER-1:0][PREG_W-1:0]  commit_preg,
    output logic [SUPER-1:0][PREG_W-1:0]  alloc_preg,
    output logic                          stall
);

    localparam int INIT_FREE = PHYS_SZ - rename_pkg::NUM_LREGS;
    localparam logic [PREG_W:0] DEPTH = (PREG_W + 1)'(PHYS_SZ);

    logic [PREG_W-1:0]              queue [PHYS_SZ];
    logic [PREG_W-1:0]              head;
    logic [PREG_W-1:0]              tail;
    logic [CNT_W-1:0]               count;
    logic [CNT_W-1:0]               n_alloc;
    logic [CNT_W-1:0]               n_rel;
    logic [SUPER-1:0][PREG_W-1:0]   rel_idx;

    // queue index base+off, wrapped at PHYS_SZ
    function automatic logic [PREG_W-1:0] step(input logic [PREG_W-1:0] base,
                                               input logic [CNT_W-1:0] off);
        logic [PREG_W:0] sum;
        sum = {1'b0, base} + (PREG_W + 1)'(off);
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return sum[PREG_W-1:0];
    endfunction

    assign stall = count < CNT_W'(SUPER);

    always_comb begin
        n_alloc = '0;
        n_rel = '0;
        for (int l = 0; l < SUPER; l++) begin
            alloc_preg[l] = '0;
            if (dec.lane_valid[l] && dec.has_dst[l]) begin
                alloc_preg[l] = queue[step(head, n_alloc)];
                n_alloc = n_alloc + 1'b1;
            end
            rel_idx[l] = step(tail, n_rel);
            if (commit_valid[l]) begin
                n_rel = n_rel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= PREG_W'(INIT_FREE);
            count <= CNT_W'(INIT_FREE);
        end else begin
            // releases are taken even while stalled
            head <= stall ? head : step(head, n_alloc);
            tail <= step(tail, n_rel);
            count <= count - (stall ? '0 : n_alloc) + n_rel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int e = 0; e < PHYS_SZ; e++) begin
                queue[e] <= (e < INIT_FREE) ? PREG_W'(rename_pkg::NUM_LREGS + e) : '0;
            end
        end else begin
            for (int l = 0; l < SUPER; l++) begin
                if (commit_valid[l]) begin
                    queue[rel_idx[l]] <= commit_preg[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table #(
    parameter int SUPER = 2,
    parameter int PHYS_SZ = 48,
    localparam int PREG_W = $clog2(PHYS_SZ)
) (
    input  logic                          clk,
    input  logic                          rst,
    decode_if.rename                      dec,
    input  logic [SUPER-1:0][PREG_W-1:0]  alloc_preg,
    input  logic                          stall,
    output logic [SUPER-1:0][PREG_W-1:0]  src1_p,
    output logic [SUPER-1:0][PREG_W-1:0]  src2_p,
    output logic [SUPER-1:0][PREG_W-1:0]  dst_p,
    output logic [SUPER-1:0][PREG_W-1:0]  old_dst_p
);

    logic [PREG_W-1:0]  map [rename_pkg::NUM_LREGS];
    logic [SUPER-1:0]   writes;

    assign writes = dec.lane_valid & dec.has_dst;

    // table entry, overridden by any earlier lane of the group
    function automatic logic [PREG_W-1:0] newest(input logic [rename_pkg::LREG_W-1:0] lreg,
                                                 input int lane);
        logic [PREG_W-1:0] p;
        p = map[lreg];
        for (int k = 0; k < SUPER; k++) begin
            if (k < lane && writes[k] && dec.dst[k] == lreg) begin
                p = alloc_preg[k];
            end
        end
        return p;
    endfunction

    always_comb begin
        for (int l = 0; l < SUPER; l++) begin
            // r0 always reads as preg 0
            if (dec.reads_src1[l] && dec.src1[l] != '0) begin
                src1_p[l] = newest(dec.src1[l], l);
            end else begin
                src1_p[l] = '0;
            end
            if (dec.reads_src2[l] && dec.src2[l] != '0) begin
                src2_p[l] = newest(dec.src2[l], l);
            end else begin
                src2_p[l] = '0;
            end
            if (writes[l]) begin
                dst_p[l] = alloc_preg[l];
                old_dst_p[l] = newest(dec.dst[l], l);
            end else begin
                dst_p[l] = '0;
                old_dst_p[l] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < rename_pkg::NUM_LREGS; r++) begin
                map[r] <= PREG_W'(r);
            end
        end else if (!stall) begin
            // later lane wins on the same logical register
            for (int l = 0; l < SUPER; l++) begin
                if (writes[l]) begin
                    map[dec.dst[l]] <= alloc_preg[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rename_stage #(
    parameter int SUPER = 2,
    parameter int PHYS_SZ = 48,
    localparam int PREG_W = $clog2(PHYS_SZ)
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        in_valid,
    input  logic [SUPER-1:0][rename_pkg::INSTR_W-1:0]   in_instr,
    output logic                                        stall,
    input  logic [SUPER-1:0]                            commit_valid,
    input  logic [SUPER-1:0][PREG_W-1:0]                commit_preg,
    output logic                                        out_valid,
    output logic [SUPER-1:0]                            out_lane_valid,
    output logic [SUPER-1:0][rename_pkg::OP_W-1:0]      out_op,
    output logic [SUPER-1:0][rename_pkg::FUNC_W-1:0]    out_func,
    output logic [SUPER-1:0][PREG_W-1:0]                out_src1_p,
    output logic [SUPER-1:0][PREG_W-1:0]                out_src2_p,
    output logic [SUPER-1:0][PREG_W-1:0]                out_dst_p,
    output logic [SUPER-1:0][PREG_W-1:0]                out_old_dst_p,
    output logic [SUPER-1:0][rename_pkg::INSTR_W-1:0]   out_imm
);

    logic [SUPER-1:0][PREG_W-1:0]               alloc_preg;
    logic [SUPER-1:0][PREG_W-1:0]               src1_p;
    logic [SUPER-1:0][PREG_W-1:0]               src2_p;
    logic [SUPER-1:0][PREG_W-1:0]               dst_p;
    logic [SUPER-1:0][PREG_W-1:0]               old_dst_p;
    logic [SUPER-1:0][rename_pkg::INSTR_W-1:0]  imm;
    logic                                       accept;

    decode_if #(.SUPER(SUPER)) dec_bus ();

    instr_decoder #(.SUPER(SUPER)) decoder_0 (
        .in_instr (in_instr),
        .in_valid (in_valid),
        .dec      (dec_bus.decoder),
        .imm_out  (imm)
    );

    free_list #(.SUPER(SUPER), .PHYS_SZ(PHYS_SZ)) free_list_0 (
        .clk          (clk),
        .rst          (rst),
        .dec          (dec_bus.rename),
        .commit_valid (commit_valid),
        .commit_preg  (commit_preg),
        .alloc_preg   (alloc_preg),
        .stall        (stall)
    );

    map_table #(.SUPER(SUPER), .PHYS_SZ(PHYS_SZ)) map_table_0 (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_bus.rename),
        .alloc_preg (alloc_preg),
        .stall      (stall),
        .src1_p     (src1_p),
        .src2_p     (src2_p),
        .dst_p      (dst_p),
        .old_dst_p  (old_dst_p)
    );

    assign accept = in_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_lane_valid <= '0;
        end else begin
            out_valid <= accept;
            out_lane_valid <= accept ? dec_bus.lane_valid : '0;
        end
    end

    // output stage payload
    always_ff @(posedge clk) begin
        if (accept) begin
            out_op <= dec_bus.op;
            out_func <= dec_bus.func;
            out_src1_p <= src1_p;
            out_src2_p <= src2_p;
            out_dst_p <= dst_p;
            out_old_dst_p <= old_dst_p;
            out_imm <= imm;
        end
    end

endmodule

`default_nettype wire

//--- tests/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

    localparam int SUPER = 2;
    localparam int PHYS_SZ = 48;
    localparam int PREG_W = $clog2(PHYS_SZ);
    // limit with margin over the summed test length
    localparam int MAX_CYCLES = 400;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic [SUPER-1:0][31:0]    in_instr;
    logic                      stall;
    logic [SUPER-1:0]          commit_valid;
    logic [SUPER-1:0][PREG_W-1:0] commit_preg;
    logic                      out_valid;
    logic [SUPER-1:0]          out_lane_valid;
    logic [SUPER-1:0][3:0]     out_op;
    logic [SUPER-1:0][2:0]     out_func;
    logic [SUPER-1:0][PREG_W-1:0] out_src1_p;
    logic [SUPER-1:0][PREG_W-1:0] out_src2_p;
    logic [SUPER-1:0][PREG_W-1:0] out_dst_p;
    logic [SUPER-1:0][PREG_W-1:0] out_old_dst_p;
    logic [SUPER-1:0][31:0]    out_imm;

    // reference model state
    int          map_m [32];
    int          fq [$];
    int          pend [$];
    int          exp_lane [SUPER];
    int          exp_op [SUPER];
    int          exp_func [SUPER];
    int          exp_s1 [SUPER];
    int          exp_s2 [SUPER];
    int          exp_dst [SUPER];
    int          exp_old [SUPER];
    logic [31:0] exp_imm [SUPER];
    logic [15:0] lfsr;
    int          cycles;

    rename_stage #(.SUPER(SUPER), .PHYS_SZ(PHYS_SZ)) uut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_instr       (in_instr),
        .stall          (stall),
        .commit_valid   (commit_valid),
        .commit_preg    (commit_preg),
        .out_valid      (out_valid),
        .out_lane_valid (out_lane_valid),
        .out_op         (out_op),
        .out_func       (out_func),
        .out_src1_p     (out_src1_p),
        .out_src2_p     (out_src2_p),
        .out_dst_p      (out_dst_p),
        .out_old_dst_p  (out_old_dst_p),
        .out_imm        (out_imm)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // one Galois step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input logic [3:0] op, input logic [2:0] func,
                                           input logic [4:0] d, input logic [4:0] s1,
                                           input logic [4:0] s2);
        return {op, func, d, s1, s2, 10'd0};
    endfunction

    function automatic logic [31:0] i_word(input logic [3:0] op, input logic [2:0] func,
                                           input logic [4:0] d, input logic [4:0] s1,
                                           input logic [14:0] imm15);
        return {op, func, d, s1, imm15};
    endfunction

    function automatic logic [31:0] j_word(input logic [3:0] op, input logic [2:0] func,
                                           input logic [4:0] d, input logic [19:0] imm20);
        return {op, func, d, imm20};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // classify one word by the opcode and function rules
    task automatic decode_word(input logic [31:0] w, output logic legal, output logic rd1,
                               output logic rd2, output logic wr, output logic jmp,
                               output logic [31:0] imm);
        logic [2:0] f;
        f = w[27:25];
        {legal, rd1, rd2, wr, jmp} = 5'b0;
        imm = '0;
        case (w[31:28])
            rename_pkg::Alu: {legal, rd1, rd2, wr} = {f != 3'd7, 3'b111};
            rename_pkg::AluImm: begin
                {legal, rd1, wr} = {f != 3'd7, 2'b11};
                imm = {{17{w[14]}}, w[14:0]};
            end
            rename_pkg::Mem: begin
                if (f == 3'd0) begin
                    {legal, rd1, wr} = 3'b111;
                    imm = {{17{w[14]}}, w[14:0]};
                end else if (f == 3'd1) begin
                    {legal, rd1, rd2} = 3'b111;
                end
            end
            rename_pkg::Branch: {legal, rd1, rd2} = {f <= 3'd3, 2'b11};
            rename_pkg::Jump: begin
                if (f == 3'd0) begin
                    {legal, wr, jmp} = 3'b111;
                    imm = {{12{w[19]}}, w[19:0]};
                end else if (f == 3'd1) begin
                    {legal, rd1, wr, jmp} = 4'b1111;
                    imm = {{17{w[14]}}, w[14:0]};
                end
            end
            rename_pkg::Lui: begin
                {legal, wr} = {f == 3'd0, 1'b1};
                imm = {{12{w[19]}}, w[19:0]};
            end
            default: legal = 1'b0;
        endcase
    endtask

    // applies one accepted group to the model and records the expected outputs
    task automatic predict_group(input logic [31:0] w0, input logic [31:0] w1);
        logic [31:0] words [SUPER];
        logic        legal;
        logic        rd1;
        logic        rd2;
        logic        wr;
        logic        jmp;
        logic        ok;
        logic        kill;
        logic [31:0] imm;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        words[0] = w0;
        words[1] = w1;
        kill = 1'b0;
        for (int l = 0; l < SUPER; l++) begin
            decode_word(words[l], legal, rd1, rd2, wr, jmp, imm);
            d = words[l][24:20];
            s1 = words[l][19:15];
            s2 = words[l][14:10];
            ok = legal && !kill;
            exp_lane[l] = ok;
            exp_op[l] = ok ? words[l][31:28] : 0;
            exp_func[l] = ok ? words[l][27:25] : 0;
            exp_imm[l] = ok ? imm : '0;
            exp_s1[l] = (ok && rd1 && s1 != 0) ? map_m[s1] : 0;
            exp_s2[l] = (ok && rd2 && s2 != 0) ? map_m[s2] : 0;
            if (ok && wr && d != 0) begin
                exp_dst[l] = fq.pop_front();
                exp_old[l] = map_m[d];
                pend.push_back(map_m[d]);
                map_m[d] = exp_dst[l];
            end else begin
                exp_dst[l] = 0;
                exp_old[l] = 0;
            end
            kill = kill || (ok && jmp);
        end
    endtask

    task automatic check_outputs();
        check_value(out_valid, 1'b1, "out_valid");
        check_value(stall, fq.size() < SUPER, "stall");
        for (int l = 0; l < SUPER; l++) begin
            check_value(out_lane_valid[l], exp_lane[l], $sformatf("lane %0d valid", l));
            check_value(out_op[l], exp_op[l], $sformatf("lane %0d op", l));
            check_value(out_func[l], exp_func[l], $sformatf("lane %0d func", l));
            check_value(out_src1_p[l], exp_s1[l], $sformatf("lane %0d src1_p", l));
            check_value(out_src2_p[l], exp_s2[l], $sformatf("lane %0d src2_p", l));
            check_value(out_dst_p[l], exp_dst[l], $sformatf("lane %0d dst_p", l));
            check_value(out_old_dst_p[l], exp_old[l], $sformatf("lane %0d old_dst_p", l));
            check_value(out_imm[l], exp_imm[l], $sformatf("lane %0d imm", l));
        end
    endtask

    // waits out any stall, then checks the registered result
    task automatic send_group(input logic [31:0] w0, input logic [31:0] w1);
        in_valid = 1'b1;
        in_instr[0] = w0;
        in_instr[1] = w1;
        while (stall) begin
            next_cycle();
        end
        predict_group(w0, w1);
        next_cycle();
        in_valid = 1'b0;
        check_outputs();
    endtask

    // returns the oldest displaced pregs through the commit port
    task automatic commit_pregs(input int n);
        int p [SUPER];
        for (int l = 0; l < n; l++) begin
            p[l] = pend.pop_front();
            commit_valid[l] = 1'b1;
            commit_preg[l] = PREG_W'(p[l]);
        end
        next_cycle();
        commit_valid = '0;
        for (int l = 0; l < n; l++) begin
            fq.push_back(p[l]);
        end
    endtask

    task automatic test_reset_first();
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(stall, 1'b0, "stall after reset");
        send_group(r_word(rename_pkg::Alu, 3'd0, 5'd3, 5'd1, 5'd2),
                   r_word(rename_pkg::Alu, 3'd1, 5'd4, 5'd5, 5'd6));
        check_value(out_src1_p[0], 1, "first group src1");
        check_value(out_src2_p[1], 6, "first group src2");
        check_value(out_dst_p[0], 32, "first dst_p lane 0");
        check_value(out_dst_p[1], 33, "first dst_p lane 1");
        check_value(out_old_dst_p[0], 3, "first old_dst_p lane 0");
        check_value(out_old_dst_p[1], 4, "first old_dst_p lane 1");
    endtask

    task automatic test_dependencies();
        send_group(r_word(rename_pkg::Alu, 3'd0, 5'd7, 5'd1, 5'd2),
                   r_word(rename_pkg::Alu, 3'd2, 5'd8, 5'd7, 5'd3));
        // 32 and 33 went to the first group
        check_value(out_dst_p[0], 34, "r7 new preg");
        check_value(out_src1_p[1], 34, "in-group bypass");
        send_group(r_word(rename_pkg::Alu, 3'd3, 5'd9, 5'd7, 5'd8),
                   r_word(rename_pkg::Alu, 3'd0, 5'd0, 5'd1, 5'd1));
        check_value(out_src1_p[0], 34, "mapping from earlier group");
        check_value(out_dst_p[1], 0, "r0 dst_p");
        check_value(out_old_dst_p[1], 0, "r0 old_dst_p");
    endtask

    task automatic test_decode_rules();
        send_group({4'd9, 28'h1234567}, r_word(rename_pkg::Alu, 3'd7, 5'd5, 5'd1, 5'd2));
        check_value(out_lane_valid, 2'b00, "illegal lanes");
        send_group(j_word(rename_pkg::Jump, 3'd0, 5'd9, 20'h80001),
                   r_word(rename_pkg::Alu, 3'd0, 5'd10, 5'd1, 5'd2));
        check_value(out_lane_valid, 2'b01, "lane after jal");
        check_value(out_imm[0], 32'hFFF80001, "jal imm20");
        send_group(r_word(rename_pkg::Mem, 3'd1, 5'd5, 5'd1, 5'd2),
                   r_word(rename_pkg::Branch, 3'd0, 5'd6, 5'd3, 5'd4));
        check_value(out_dst_p, '0, "store and branch dst_p");
        send_group(i_word(rename_pkg::AluImm, 3'd0, 5'd10, 5'd11, 15'h7FFB),
                   j_word(rename_pkg::Lui, 3'd0, 5'd12, 20'h12345));
        check_value(out_src2_p[0], 0, "unused src2");
        check_value(out_src1_p[1], 0, "lui src1");
        check_value(out_imm[0], 32'hFFFFFFFB, "imm15 sign extension");
        check_value(out_imm[1], 32'h00012345, "imm20 positive");
    endtask

    task automatic test_exhaustion();
        logic [31:0] wa;
        logic [31:0] wb;
        int          c0;
        int          c1;
        wa = r_word(rename_pkg::Alu, 3'd0, 5'd20, 5'd1, 5'd2);
        wb = r_word(rename_pkg::Alu, 3'd0, 5'd21, 5'd20, 5'd3);
        while (fq.size() >= SUPER) begin
            if (fq.size() % 2 == 1) begin
                send_group(wa, r_word(rename_pkg::Mem, 3'd1, 5'd0, 5'd1, 5'd2));
            end else begin
                send_group(wa, wb);
            end
        end
        check_value(stall, 1'b1, "stall when free list is low");
        in_valid = 1'b1;
        in_instr[0] = wa;
        in_instr[1] = wb;
        repeat (2) begin
            next_cycle();
            check_value(out_valid, 1'b0, "held group not accepted");
            check_value(stall, 1'b1, "stall while held");
        end
        c0 = pend[0];
        c1 = pend[1];
        commit_pregs(2);
        check_value(stall, 1'b0, "stall after commit");
        send_group(wa, wb);
        check_value(out_dst_p[0], c0, "first committed preg reused");
        check_value(out_dst_p[1], c1, "second committed preg reused");
    endtask

    task automatic test_random_run();
        logic [31:0] w0;
        logic [31:0] w1;
        int          n;
        for (int g = 0; g < 40; g++) begin
            if (rand_bits(1) == 1 && pend.size() > 0) begin
                n = 1 + rand_bits(1);
                commit_pregs(n < pend.size() ? n : pend.size());
            end
            while (fq.size() < SUPER) begin
                commit_pregs(pend.size() < SUPER ? pend.size() : SUPER);
            end
            // op kept below 8 so most words are legal
            w0 = rand_bits(31);
            w1 = rand_bits(31);
            send_group(w0, w1);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        commit_valid = '0;
        commit_preg = '0;
        cycles = 0;
        lfsr = 16'd31690;
        for (int r = 0; r < 32; r++) begin
            map_m[r] = r;
        end
        for (int p = 32; p < PHYS_SZ; p++) begin
            fq.push_back(p);
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_first();
        test_dependencies();
        test_decode_rules();
        test_exhaustion();
        test_random_run();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rename.f
rtl/rename_pkg.sv
rtl/decode_if.sv
rtl/instr_decoder.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rename_stage.sv
tests/rename_tb.sv
